/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+verification
rtl/core_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/register_file.sv
rtl/instr_fetch.sv
rtl/prefetch_fifo.sv
rtl/exec_unit.sv
rtl/core_top.sv
verification/tb_core_top.sv

/* rtl/core_cfg_pkg.sv */
package core_cfg_pkg;

  // Data path and address width
  localparam int unsigned XLEN = 32;

  // One data or address value
  typedef logic [XLEN-1:0] word_t;

  // Register index width, 32 architectural registers
  localparam int unsigned RF_ADDR_W = 5;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////
  // Default configuration
  //////////////////////

  // Prefetch FIFO depth, also the fetch credit limit
  localparam int unsigned DEFAULT_FIFO_DEPTH = 4;

endpackage

/* rtl/core_top.sv */
module core_top #(
  parameter int unsigned FIFO_DEPTH = core_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  core_cfg_pkg::word_t    boot_addr_i,
  // Instruction bus
  output logic                   instr_req_o,
  output core_cfg_pkg::word_t    instr_addr_o,
  input  logic                   instr_rvalid_i,
  input  core_cfg_pkg::word_t    instr_rdata_i,
  // Write-back report
  output logic                   rf_we_o,
  output core_cfg_pkg::rf_addr_t rf_waddr_o,
  output core_cfg_pkg::word_t    rf_wdata_o
);
  import core_cfg_pkg::*;

  // FIFO head towards execute
  logic  fifo_valid;
  word_t fifo_data;
  // Accept strobe, doubles as credit return
  logic  exec_pop;

  //////////////////////
  // Fetch
  //////////////////////

  instr_fetch #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) instr_fetch_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .boot_addr_i  ( boot_addr_i  ),
    .pop_i        ( exec_pop     ),
    .instr_req_o  ( instr_req_o  ),
    .instr_addr_o ( instr_addr_o )
  );

  //////////////////////
  // Prefetch buffer
  //////////////////////

  // Every answer is pushed as it arrives
  prefetch_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) prefetch_fifo_i (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .push_i  ( instr_rvalid_i ),
    .data_i  ( instr_rdata_i  ),
    .pop_i   ( exec_pop       ),
    .valid_o ( fifo_valid     ),
    .data_o  ( fifo_data      )
  );

  //////////////////////
  // Execute
  //////////////////////

  exec_unit exec_unit_i (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .valid_i    ( fifo_valid ),
    .instr_i    ( fifo_data  ),
    .pop_o      ( exec_pop   ),
    .rf_we_o    ( rf_we_o    ),
    .rf_waddr_o ( rf_waddr_o ),
    .rf_wdata_o ( rf_wdata_o )
  );

endmodule

/* rtl/exec_unit.sv */
module exec_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  core_cfg_pkg::word_t    instr_i,
  output logic                   pop_o,
  output logic                   rf_we_o,
  output core_cfg_pkg::rf_addr_t rf_waddr_o,
  output core_cfg_pkg::word_t    rf_wdata_o
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  // Decode fields
  logic [6:0] funct7;
  logic [2:0] funct3;
  rf_addr_t   rs1;
  rf_addr_t   rs2;
  rf_addr_t   rd;
  word_t      imm_i;
  word_t      imm_u;
  alu_op_e    op;
  logic       use_imm;
  logic       is_shift;

  // Operands and result
  word_t      rdata_a;
  word_t      rdata_b;
  word_t      opnd_b;
  word_t      alu_res;
  logic [4:0] shamt;

  // Execute state with _d as the value after the coming edge
  word_t      res_q, res_d;
  logic [4:0] cnt_q, cnt_d;
  logic       left_q, left_d;
  rf_addr_t   rd_q, rd_d;
  logic       shift_q, shift_d;
  logic       wr_q, wr_d;
  logic       ret_q, ret_d;

  //////////////////////
  // Decode
  //////////////////////

  assign funct7 = instr_i[31:25];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign rd     = instr_i[11:7];
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  always_comb begin
    op      = ALU_NONE;
    use_imm = 1'b0;
    case (instr_i[6:0])
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD_SUB: op = ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_XOR:     op = ALU_XOR;
            F3_SRL:     op = ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_NONE;
          endcase
        end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
          op = ALU_SUB;
        end
      end
      // Only ADDI is kept from the immediate group
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD_SUB) begin
          op      = ALU_ADD;
          use_imm = 1'b1;
        end
      end
      OPC_LUI: op = ALU_LUI;
      default: op = ALU_NONE;
    endcase
  end

  assign is_shift = (op == ALU_SLL) || (op == ALU_SRL);

  //////////////////////
  // Operands and ALU
  //////////////////////

  register_file register_file_i (
    .clk_i     ( clk_i         ),
    .raddr_a_i ( rs1           ),
    .raddr_b_i ( rs2           ),
    .rdata_a_o ( rdata_a       ),
    .rdata_b_o ( rdata_b       ),
    .we_i      ( ret_d && wr_d ),
    .waddr_i   ( rd_d          ),
    .wdata_i   ( res_d         )
  );

  assign opnd_b = use_imm ? imm_i : rdata_b;
  assign shamt  = rdata_b[4:0];

  // Shifts pass rs1 through to the serial shifter
  always_comb begin
    case (op)
      ALU_ADD: alu_res = rdata_a + opnd_b;
      ALU_SUB: alu_res = rdata_a - opnd_b;
      ALU_AND: alu_res = rdata_a & opnd_b;
      ALU_OR:  alu_res = rdata_a | opnd_b;
      ALU_XOR: alu_res = rdata_a ^ opnd_b;
      ALU_LUI: alu_res = imm_u;
      ALU_SLL: alu_res = rdata_a;
      ALU_SRL: alu_res = rdata_a;
      default: alu_res = '0;
    endcase
  end

  //////////////////////
  // Sequencing
  //////////////////////

  // Head word taken unless a shift is still running
  assign pop_o = valid_i && !shift_q;

  always_comb begin
    res_d   = res_q;
    cnt_d   = cnt_q;
    left_d  = left_q;
    rd_d    = rd_q;
    shift_d = shift_q;
    wr_d    = wr_q;
    ret_d   = 1'b0;
    if (shift_q) begin
      // One bit per cycle and retire after the last one
      res_d = left_q ? {res_q[XLEN-2:0], 1'b0} : {1'b0, res_q[XLEN-1:1]};
      cnt_d = cnt_q - 5'd1;
      if (cnt_q == 5'd1) begin
        shift_d = 1'b0;
        ret_d   = 1'b1;
      end
    end else if (pop_o) begin
      res_d  = alu_res;
      rd_d   = rd;
      wr_d   = (op != ALU_NONE) && (rd != '0);
      left_d = op == ALU_SLL;
      cnt_d  = shamt;
      if (is_shift && shamt != 5'd0) begin
        shift_d = 1'b1;
      end else begin
        ret_d = 1'b1;
      end
    end
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      shift_q <= 1'b0;
      ret_q   <= 1'b0;
      wr_q    <= 1'b0;
    end else begin
      shift_q <= shift_d;
      ret_q   <= ret_d;
      wr_q    <= wr_d;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    res_q  <= res_d;
    cnt_q  <= cnt_d;
    left_q <= left_d;
    rd_q   <= rd_d;
  end

  // Register file already holds the value in the retire cycle
  assign rf_we_o    = ret_q && wr_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = res_q;

  // A NOP retires the next cycle without a write-back
  nop_silent_a: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_o && instr_i == NOP_WORD |=> !rf_we_o);

endmodule

/* rtl/instr_fetch.sv */
module instr_fetch #(
  parameter int unsigned FIFO_DEPTH = core_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_cfg_pkg::word_t boot_addr_i,
  input  logic                pop_i,
  output logic                instr_req_o,
  output core_cfg_pkg::word_t instr_addr_o
);
  import core_cfg_pkg::*;

  // Credit counter must hold 0 to FIFO_DEPTH
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  // Program counter, next address to request
  word_t         pc_q;
  // Words requested but not yet popped by execute
  logic [CW-1:0] credit_q;
  // Goes high one cycle after reset release
  logic          fetch_en_q;
  logic          has_credit;

  //////////////////////
  // Request
  //////////////////////

  // Every slot of the FIFO is either free or already promised
  assign has_credit   = credit_q < CW'(FIFO_DEPTH);
  assign instr_req_o  = fetch_en_q && has_credit;
  assign instr_addr_o = pc_q;

  // Sequential PC, boot address loaded while in reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q       <= boot_addr_i;
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
      if (instr_req_o) begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

  //////////////////////
  // Credit tracking
  //////////////////////

  // Up on request, down on pop, both cancel out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= '0;
    end else begin
      case ({instr_req_o, pop_i})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // A pop without a matching request would wrap the counter
  credit_max_a: assert property (@(posedge clk_i) disable iff (rst_i)
    credit_q <= CW'(FIFO_DEPTH));

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

  //////////////////////
  // Major opcodes
  //////////////////////

  // Only the register, immediate and LUI groups are decoded
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  //////////////////////
  // Minor fields
  //////////////////////

  // funct3 values for the kept operations
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 selects base or alternate form (SUB)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Decoded operation
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI,
    ALU_NONE
  } alu_op_e;

  // ADDI x0,x0,0
  localparam core_cfg_pkg::word_t NOP_WORD = 32'h0000_0013;

endpackage

/* rtl/prefetch_fifo.sv */
module prefetch_fifo #(
  parameter int unsigned DEPTH = core_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  core_cfg_pkg::word_t data_i,
  input  logic                pop_i,
  output logic                valid_o,
  output core_cfg_pkg::word_t data_o
);
  import core_cfg_pkg::*;

  // Pointer and occupancy widths
  localparam int unsigned PW = $clog2(DEPTH);
  localparam int unsigned CW = $clog2(DEPTH + 1);

  word_t         mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;

  // Wrap at DEPTH, not only at powers of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    ptr_inc = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head word, visible the cycle after its push
  assign valid_o = count_q != '0;
  assign data_o  = mem_q[rd_ptr_q];

  // Fetch credit keeps pushes away from a full buffer
  no_overflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> count_q < CW'(DEPTH));

  no_underflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> count_q != '0);

endmodule

/* rtl/register_file.sv */
module register_file (
  input  logic                   clk_i,
  // Read ports, combinational
  input  core_cfg_pkg::rf_addr_t raddr_a_i,
  input  core_cfg_pkg::rf_addr_t raddr_b_i,
  output core_cfg_pkg::word_t    rdata_a_o,
  output core_cfg_pkg::word_t    rdata_b_o,
  // Write port
  input  logic                   we_i,
  input  core_cfg_pkg::rf_addr_t waddr_i,
  input  core_cfg_pkg::word_t    wdata_i
);
  import core_cfg_pkg::*;

  // Entry 0 is never written
  word_t regs_q [32];

  //////////////////////
  // Write
  //////////////////////

  // Writes to x0 are dropped
  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////
  // Read
  //////////////////////

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* verification/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns: test name, instruction word, expected rd (NO_WB if none), expected value
// Row n sits at boot address + 4*n
task automatic load_program();
  // Immediates and upper immediate
  add_row("addi pos", i_word(3'b000, 1, 0, 5), 1, 32'h0000_0005);
  add_row("addi neg", i_word(3'b000, 2, 0, -3), 2, 32'hFFFF_FFFD);
  add_row("add", r_word(7'h00, 3'b000, 3, 1, 2), 3, 32'h0000_0002);
  add_row("sub", r_word(7'h20, 3'b000, 4, 1, 2), 4, 32'h0000_0008);
  add_row("lui", u_word(5, 20'h12345), 5, 32'h1234_5000);
  add_row("addi after lui", i_word(3'b000, 5, 5, 12'h678), 5, 32'h1234_5678);
  // Logic group
  add_row("and", r_word(7'h00, 3'b111, 6, 5, 2), 6, 32'h1234_5678);
  add_row("or", r_word(7'h00, 3'b110, 7, 5, 1), 7, 32'h1234_567D);
  add_row("xor", r_word(7'h00, 3'b100, 8, 5, 2), 8, 32'hEDCB_A985);
  // No write-back expected here
  add_row("addi to x0", i_word(3'b000, 0, 1, 7), NO_WB, 32'h0);
  add_row("add to x0", r_word(7'h00, 3'b000, 0, 5, 5), NO_WB, 32'h0);
  add_row("bad opcode", 32'hFFFF_FFFF, NO_WB, 32'h0);
  add_row("slti dropped", i_word(3'b010, 9, 1, 1), NO_WB, 32'h0);
  add_row("mul dropped", r_word(7'h01, 3'b000, 9, 1, 2), NO_WB, 32'h0);
  add_row("x0 reads zero", r_word(7'h00, 3'b000, 9, 0, 0), 9, 32'h0000_0000);
  // Serial shifts
  add_row("addi one", i_word(3'b000, 10, 0, 1), 10, 32'h0000_0001);
  add_row("sll by 0", r_word(7'h00, 3'b001, 11, 5, 0), 11, 32'h1234_5678);
  add_row("addi 31", i_word(3'b000, 12, 0, 31), 12, 32'h0000_001F);
  add_row("sll by 31", r_word(7'h00, 3'b001, 13, 10, 12), 13, 32'h8000_0000);
  add_row("srl by 31", r_word(7'h00, 3'b101, 14, 13, 12), 14, 32'h0000_0001);
  add_row("addi 4", i_word(3'b000, 15, 0, 4), 15, 32'h0000_0004);
  add_row("srl by 4", r_word(7'h00, 3'b101, 16, 5, 15), 16, 32'h0123_4567);
  add_row("sll by 4", r_word(7'h00, 3'b001, 17, 5, 15), 17, 32'h2345_6780);
  add_row("addi 13", i_word(3'b000, 18, 0, 13), 18, 32'h0000_000D);
  add_row("sll by 13", r_word(7'h00, 3'b001, 19, 5, 18), 19, 32'h8ACF_0000);
  add_row("srl by 13", r_word(7'h00, 3'b101, 20, 5, 18), 20, 32'h0000_91A2);
  add_row("addi all ones", i_word(3'b000, 21, 0, -1), 21, 32'hFFFF_FFFF);
  add_row("srl ones by 31", r_word(7'h00, 3'b101, 22, 21, 12), 22, 32'h0000_0001);
  add_row("sll ones by 1", r_word(7'h00, 3'b001, 23, 21, 10), 23, 32'hFFFF_FFFE);
  // Only the low five bits of rs2 count
  add_row("addi 33", i_word(3'b000, 24, 0, 33), 24, 32'h0000_0021);
  add_row("srl by 33", r_word(7'h00, 3'b101, 25, 21, 24), 25, 32'h7FFF_FFFF);
  add_row("sub wraps", r_word(7'h20, 3'b000, 26, 3, 4), 26, 32'hFFFF_FFFA);
  add_row("addi min imm", i_word(3'b000, 28, 0, -2048), 28, 32'hFFFF_F800);
  add_row("srl neg", r_word(7'h00, 3'b101, 29, 28, 15), 29, 32'h0FFF_FF80);
  add_row("xor shifted", r_word(7'h00, 3'b100, 30, 29, 28), 30, 32'hF000_0780);
  add_row("sll by 13 small", r_word(7'h00, 3'b001, 31, 1, 18), 31, 32'h0000_A000);
  add_row("nop", 32'h0000_0013, NO_WB, 32'h0);
endtask

`endif

/* verification/tb_core_top.sv */
module tb_core_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          FIFO_DEPTH = 4;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0100;
  // Row mark, no write-back expected
  localparam int          NO_WB      = -1;

  // DUT ports
  logic        clk_i;
  logic        rst_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        rf_we_o;
  logic [4:0]  rf_waddr_o;
  logic [31:0] rf_wdata_o;

  // Program table, one entry per word
  string       prog_name [$];
  logic [31:0] prog_instr [$];
  int          prog_rd [$];
  logic [31:0] prog_val [$];

  // Requests waiting for an answer
  logic [31:0] addr_q [$];
  int          due_q [$];

  int          cyc = 0;
  int          rel_cyc = 0;
  int          max_cycles = 0;
  int          req_count = 0;
  int          answered = 0;
  int          checked = 0;
  int          errors = 0;
  logic [31:0] lfsr_q = 32'h3124_e7de;

  core_top #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) dut0 (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .rf_we_o        ( rf_we_o        ),
    .rf_waddr_o     ( rf_waddr_o     ),
    .rf_wdata_o     ( rf_wdata_o     )
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////
  // Encoders and table
  //////////////////////

  // R-type, OP major opcode
  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    r_word = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  // I-type, OP-IMM major opcode
  function automatic logic [31:0] i_word(input logic [2:0] f3, input int rd,
                                         input int rs1, input int imm);
    i_word = {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
  endfunction

  // U-type, LUI
  function automatic logic [31:0] u_word(input int rd, input logic [19:0] imm);
    u_word = {imm, 5'(rd), 7'b0110111};
  endfunction

  task automatic add_row(input string name, input logic [31:0] word, input int rd,
                         input logic [31:0] value);
    prog_name.push_back(name);
    prog_instr.push_back(word);
    prog_rd.push_back(rd);
    prog_val.push_back(value);
  endtask

  `include "tb_program.svh"

  //////////////////////
  // Checks and report
  //////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d write-backs checked, %0d requests, %0d answers, %0d errors",
             checked, req_count, answered, errors);
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // Cycle count and run limit
  task automatic count_cycles();
    forever begin
      @(posedge clk_i);
      cyc++;
      if (cyc >= max_cycles) begin
        $display("Error: write-backs stopped, run ended after %0d cycles", cyc);
        errors++;
        print_summary();
        $display("Testbench failed");
        $finish;
      end
    end
  endtask

  //////////////////////
  // Instruction memory
  //////////////////////

  // In-order answers, 1 to 4 cycles each
  task automatic serve_memory();
    int idx;
    int lat;
    forever begin
      @(negedge clk_i);
      instr_rvalid_i = 1'b0;
      if (rst_i) begin
        // Quiet bus and no write-back while in reset
        if (cyc > 0) begin
          check_value("req in reset", 32'h0, 32'(instr_req_o));
          check_value("we in reset", 32'h0, 32'(rf_we_o));
        end
      end else begin
        if (answered == 0) begin
          check_value("we before any answer", 32'h0, 32'(rf_we_o));
        end
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
          idx = int'((addr_q[0] - BOOT_ADDR) >> 2);
          // Past the table the program runs on NOPs
          if (idx < prog_instr.size()) begin
            instr_rdata_i = prog_instr[idx];
          end else begin
            instr_rdata_i = isa_pkg::NOP_WORD;
          end
          instr_rvalid_i = 1'b1;
          void'(addr_q.pop_front());
          void'(due_q.pop_front());
          answered++;
        end
        if (instr_req_o === 1'b1) begin
          // First request right after reset release
          if (req_count == 0) begin
            check_value("first request cycle", 32'(rel_cyc + 1), 32'(cyc));
          end
          check_value("request address", BOOT_ADDR + 32'(4 * req_count), instr_addr_o);
          // Two LFSR bits give the extra latency
          lat = 1;
          for (int b = 0; b < 2; b++) begin
            if (lfsr_q[0]) begin
              lat = lat + (1 << b);
            end
            lfsr_q = lfsr_next(lfsr_q);
          end
          addr_q.push_back(instr_addr_o);
          due_q.push_back(cyc + lat);
          req_count++;
        end
      end
    end
  endtask

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin : main
    rst_i          = 1'b1;
    boot_addr_i    = BOOT_ADDR;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    load_program();
    // Longest shift plus memory latency per row
    max_cycles = prog_instr.size() * 40 + 100;
    fork
      count_cycles();
      serve_memory();
    join_none

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rel_cyc = cyc;
    rst_i   = 1'b0;

    // Write-backs in program order
    for (int i = 0; i < prog_instr.size(); i++) begin
      if (prog_rd[i] != NO_WB) begin
        @(negedge clk_i);
        while (rf_we_o !== 1'b1) @(negedge clk_i);
        check_value({prog_name[i], " rd"}, 32'(prog_rd[i]), 32'(rf_waddr_o));
        check_value(prog_name[i], prog_val[i], rf_wdata_o);
        checked++;
        // Rows up to i are popped, credit bounds the rest
        if (req_count - (i + 1) > FIFO_DEPTH) begin
          $display("Error: %0d requests outstanding past execute at %s, limit %0d",
                   req_count - (i + 1), prog_name[i], FIFO_DEPTH);
          errors++;
        end
      end
    end

    // Trailing NOPs stay silent
    repeat (20) begin
      @(negedge clk_i);
      if (rf_we_o !== 1'b0) begin
        $display("Error: unexpected write-back to x%0d after the last table row",
                 rf_waddr_o);
        errors++;
      end
    end

    print_summary();
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
